/* logic/sprite_pkg.sv */
package sprite_pkg;

	// ----------------------------------------------------------------------
	// geometry and widths
	// ----------------------------------------------------------------------
	localparam int NUM_SPRITES  = 32;
	localparam int SPRITE_NUM_W = 5;
	localparam int LINE_PIXELS  = 360;  // visible width
	localparam int LINE_ADDR_W  = 9;
	localparam int VLINE_W      = 9;
	localparam int PIXEL_CLOCKS = 4;    // clk per shown pixel
	localparam int MEM_ADDR_W   = 21;   // word address, 2M x 16
	localparam int WORD_W       = 16;
	localparam int OFFS_W       = 14;
	localparam int SIZE_W       = 7;    // XSZ and YSZ fields
	localparam int COLOR_W      = 6;
	localparam int DESC_ADDR_W  = 8;
	localparam int STATE_W      = 4;

	// descriptor registers, address is {sprite, index}
	localparam logic [2:0] REG_XPOS_LO     = 3'd0;
	localparam logic [2:0] REG_XPOS_HI_XSZ = 3'd1;
	localparam logic [2:0] REG_YPOS_LO     = 3'd2;
	localparam logic [2:0] REG_YPOS_HI_YSZ = 3'd3;
	localparam logic [2:0] REG_MODE_PAL    = 3'd4;
	localparam logic [2:0] REG_ADR_LO      = 3'd5;
	localparam logic [2:0] REG_ADR_MID     = 3'd6;
	localparam logic [2:0] REG_ADR_HI      = 3'd7;

	typedef enum logic [1:0] {
		CRES_OFF  = 2'd0,
		CRES_4C   = 2'd1,
		CRES_16C  = 2'd2,
		CRES_TRUE = 2'd3
	} cres_e;

	// ----------------------------------------------------------------------
	// engine FSM states
	// ----------------------------------------------------------------------
	localparam logic [STATE_W-1:0] ST_IDLE = 4'd0;
	localparam logic [STATE_W-1:0] ST_MODE = 4'd1;
	localparam logic [STATE_W-1:0] ST_YLO  = 4'd2;
	localparam logic [STATE_W-1:0] ST_YHI  = 4'd3;
	localparam logic [STATE_W-1:0] ST_ALO  = 4'd4;
	localparam logic [STATE_W-1:0] ST_AMID = 4'd5;
	localparam logic [STATE_W-1:0] ST_AHI  = 4'd6;
	localparam logic [STATE_W-1:0] ST_XLO  = 4'd7;
	localparam logic [STATE_W-1:0] ST_XHI  = 4'd8;
	localparam logic [STATE_W-1:0] ST_WAIT = 4'd9;   // word from memory
	localparam logic [STATE_W-1:0] ST_PIX  = 4'd10;  // unpack, one pixel per clk
	localparam logic [STATE_W-1:0] ST_NEXT = 4'd11;

	// one memory word, leftmost pixel in the top bits
	typedef union packed {
		logic [7:0][1:0] c4;
		logic [3:0][3:0] c16;
		struct packed {
			logic               opaque;
			logic               spare;
			logic [COLOR_W-1:0] color;
		} [1:0] tc;
	} sprite_word_u;

endpackage

/* logic/sprite_regs.sv */
`timescale 1ns/1ps

module sprite_regs (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               host_we,
	input  logic [sprite_pkg::DESC_ADDR_W:0]   host_addr,
	input  logic [7:0]                         host_wdata,
	input  logic [sprite_pkg::DESC_ADDR_W-1:0] desc_addr,
	output logic [7:0]                         desc_data,
	input  logic [sprite_pkg::DESC_ADDR_W-1:0] pal_addr,
	output logic [sprite_pkg::COLOR_W-1:0]     pal_color
);
	import sprite_pkg::*;

	logic [7:0]         desc_mem [2**DESC_ADDR_W];
	logic [COLOR_W-1:0] pal_mem [2**DESC_ADDR_W];
	logic               desc_we;
	logic               pal_we;

	// top address bit picks palette over descriptors
	assign desc_we = host_we && !host_addr[DESC_ADDR_W];
	assign pal_we  = host_we && host_addr[DESC_ADDR_W];

	// ----------------------------------------------------------------------
	// descriptor file
	// ----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			// all sprites start in mode off
			for (int i = 0; i < NUM_SPRITES; i++)
				desc_mem[{SPRITE_NUM_W'(i), REG_MODE_PAL}] <= '0;
		end
		else if (desc_we)
			desc_mem[host_addr[DESC_ADDR_W-1:0]] <= host_wdata;
	end

	assign desc_data = desc_mem[desc_addr];  // async read

	// ----------------------------------------------------------------------
	// palette
	// ----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (pal_we)
			pal_mem[host_addr[DESC_ADDR_W-1:0]] <= host_wdata[COLOR_W-1:0];
	end

	assign pal_color = pal_mem[pal_addr];

endmodule

/* logic/sprite_engine.sv */
`timescale 1ns/1ps

module sprite_engine (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               line_start,
	input  logic                               pre_vline,
	output logic [sprite_pkg::DESC_ADDR_W-1:0] desc_addr,
	input  logic [7:0]                         desc_data,
	output logic [sprite_pkg::DESC_ADDR_W-1:0] pal_addr,
	input  logic [sprite_pkg::COLOR_W-1:0]     pal_color,
	output logic [sprite_pkg::MEM_ADDR_W-1:0]  spr_addr,
	output logic                               spr_mrq,
	input  logic [sprite_pkg::WORD_W-1:0]      spr_dat,
	input  logic                               spr_drdy,
	output logic                               wr_en,
	output logic [sprite_pkg::LINE_ADDR_W-1:0] wr_addr,
	output logic [sprite_pkg::COLOR_W:0]       wr_data,
	output logic                               busy
);
	import sprite_pkg::*;

	logic [STATE_W-1:0]      state;
	logic [SPRITE_NUM_W-1:0] num;          // sprite being scanned
	logic [VLINE_W-1:0]      vline;
	logic [OFFS_W-1:0]       offs_mem [NUM_SPRITES];
	logic [OFFS_W-1:0]       offs;
	logic [MEM_ADDR_W-1:0]   adr;
	logic [LINE_ADDR_W-1:0]  xcur;
	logic [7:0]              ylo;
	cres_e                   cres;
	logic [COLOR_W-1:0]      pal;
	logic [SIZE_W-1:0]       words_left;   // still to unpack
	logic [SIZE_W-1:0]       req_left;     // still to request
	logic [2:0]              pcnt;         // pixel within word
	logic [2:0]              pix_sel;
	sprite_word_u            sdbuf;
	sprite_word_u            nbuf;
	logic                    nvalid;
	logic                    mem_drop;
	logic                    fetching;
	logic [2:0]              reg_idx;
	logic [VLINE_W-1:0]      ypos_full;
	logic [VLINE_W:0]        yend;
	logic                    y_hit;
	logic                    pix_opaque;
	logic                    pix_last;
	logic [COLOR_W-1:0]      pix_color;

	// ----------------------------------------------------------------------
	// descriptor read address and visibility test
	// ----------------------------------------------------------------------
	always_comb
	begin
		case (state)
			ST_YLO:  reg_idx = REG_YPOS_LO;
			ST_YHI:  reg_idx = REG_YPOS_HI_YSZ;
			ST_ALO:  reg_idx = REG_ADR_LO;
			ST_AMID: reg_idx = REG_ADR_MID;
			ST_AHI:  reg_idx = REG_ADR_HI;
			ST_XLO:  reg_idx = REG_XPOS_LO;
			ST_XHI:  reg_idx = REG_XPOS_HI_XSZ;
			default: reg_idx = REG_MODE_PAL;
		endcase
	end

	assign desc_addr = {num, reg_idx};

	assign ypos_full = {desc_data[0], ylo};
	assign yend      = {1'b0, ypos_full} + (VLINE_W + 1)'(desc_data[7:1]);
	assign y_hit     = (vline >= ypos_full) && ({1'b0, vline} < yend);

	assign fetching = (state == ST_WAIT) || (state == ST_PIX);

	// ----------------------------------------------------------------------
	// pixel unpack
	// ----------------------------------------------------------------------
	assign pix_sel = ~pcnt;  // pixel 0 sits in the top bits

	always_comb
	begin
		pal_addr   = '0;
		pix_color  = pal_color;
		pix_opaque = 1'b0;
		pix_last   = 1'b0;
		case (cres)
			CRES_4C:
			begin
				pal_addr   = {pal, sdbuf.c4[pix_sel]};
				pix_opaque = |sdbuf.c4[pix_sel];
				pix_last   = (pcnt == 3'd7);
			end
			CRES_16C:
			begin
				pal_addr   = {pal[5:2], sdbuf.c16[pix_sel[1:0]]};
				pix_opaque = |sdbuf.c16[pix_sel[1:0]];
				pix_last   = (pcnt == 3'd3);
			end
			CRES_TRUE:
			begin
				pix_color  = sdbuf.tc[pix_sel[0]].color;  // no palette
				pix_opaque = sdbuf.tc[pix_sel[0]].opaque;
				pix_last   = (pcnt == 3'd1);
			end
			default: ;
		endcase
	end

	// ----------------------------------------------------------------------
	// scan FSM and memory fetch
	// ----------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state    <= ST_IDLE;
			num      <= '0;
			vline    <= '0;
			busy     <= 1'b0;
			spr_mrq  <= 1'b0;
			wr_en    <= 1'b0;
			nvalid   <= 1'b0;
			mem_drop <= 1'b0;
		end
		else
		begin
			wr_en <= 1'b0;

			// memory side, a word may land while the previous one unpacks
			if (spr_mrq && spr_drdy)
			begin
				spr_mrq  <= 1'b0;
				nbuf     <= spr_dat;
				nvalid   <= !mem_drop;
				mem_drop <= 1'b0;
			end
			else if (fetching && !spr_mrq && !nvalid && req_left != '0)
			begin
				spr_mrq       <= 1'b1;
				spr_addr      <= adr + MEM_ADDR_W'(offs);
				offs          <= offs + 1'b1;
				offs_mem[num] <= offs + 1'b1;  // carried to next line
				req_left      <= req_left - 1'b1;
			end

			if (line_start)
			begin
				vline    <= pre_vline ? '0 : vline + 1'b1;
				num      <= '0;
				busy     <= 1'b1;
				nvalid   <= 1'b0;
				mem_drop <= spr_mrq && !spr_drdy;  // old request still open
				state    <= ST_MODE;
			end
			else
			begin
				case (state)
					ST_MODE:
						if (desc_data[7:6] == CRES_OFF)
							state <= ST_NEXT;
						else
						begin
							cres  <= cres_e'(desc_data[7:6]);
							pal   <= desc_data[5:0];
							state <= ST_YLO;
						end
					ST_YLO:
					begin
						ylo   <= desc_data;
						state <= ST_YHI;
					end
					ST_YHI:
						if (y_hit)
						begin
							offs  <= (vline == ypos_full) ? '0 : offs_mem[num];
							state <= ST_ALO;
						end
						else
							state <= ST_NEXT;
					ST_ALO:
					begin
						adr[7:0] <= desc_data;
						state    <= ST_AMID;
					end
					ST_AMID:
					begin
						adr[15:8] <= desc_data;
						state     <= ST_AHI;
					end
					ST_AHI:
					begin
						adr[MEM_ADDR_W-1:16] <= desc_data[MEM_ADDR_W-17:0];
						state                <= ST_XLO;
					end
					ST_XLO:
					begin
						xcur[7:0] <= desc_data;
						state     <= ST_XHI;
					end
					ST_XHI:
					begin
						xcur[8]    <= desc_data[0];
						words_left <= desc_data[7:1];
						req_left   <= desc_data[7:1];
						pcnt       <= '0;
						state      <= (desc_data[7:1] == '0) ? ST_NEXT : ST_WAIT;
					end
					ST_WAIT:
						if (nvalid)
						begin
							sdbuf  <= nbuf;
							nvalid <= 1'b0;
							state  <= ST_PIX;
						end
					ST_PIX:
					begin
						wr_en   <= pix_opaque;
						wr_addr <= xcur;
						wr_data <= {1'b1, pix_color};
						xcur    <= xcur + 1'b1;
						pcnt    <= pcnt + 1'b1;
						if (pix_last)
						begin
							pcnt <= '0;
							if (words_left == SIZE_W'(1))
								state <= ST_NEXT;
							else
							begin
								words_left <= words_left - 1'b1;
								if (nvalid)
								begin
									sdbuf  <= nbuf;
									nvalid <= 1'b0;
								end
								else
									state <= ST_WAIT;
							end
						end
					end
					ST_NEXT:
						if (num == SPRITE_NUM_W'(NUM_SPRITES - 1))
						begin
							busy  <= 1'b0;  // line done
							state <= ST_IDLE;
						end
						else
						begin
							num   <= num + 1'b1;
							state <= ST_MODE;
						end
					default: ;
				endcase
			end
		end
	end

endmodule

/* logic/line_buffer.sv */
`timescale 1ns/1ps

module line_buffer (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               line_start,
	input  logic                               wr_en,
	input  logic [sprite_pkg::LINE_ADDR_W-1:0] wr_addr,
	input  logic [sprite_pkg::COLOR_W:0]       wr_data,
	output logic                               l_sel,
	output logic [sprite_pkg::COLOR_W-1:0]     spixel,
	output logic                               spx_en,
	output logic                               px_tick
);
	import sprite_pkg::*;

	// entry is {opaque, colour}; l_sel names the draw half
	logic [COLOR_W:0]       lbuf [2][2**LINE_ADDR_W];
	logic [1:0]             phase;
	logic [LINE_ADDR_W-1:0] rd_ptr;
	logic                   rd_active;
	logic                   rd_now;
	logic                   show_sel;
	logic [LINE_ADDR_W-1:0] rd_addr;
	logic [COLOR_W:0]       rd_data;

	// pixel 0 is read in the line_start cycle itself, before the swap lands
	assign rd_now   = line_start || (rd_active && phase == '0);
	assign show_sel = line_start ? l_sel : ~l_sel;
	assign rd_addr  = line_start ? '0 : rd_ptr;
	assign rd_data  = lbuf[show_sel][rd_addr];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			l_sel     <= 1'b0;
			phase     <= '0;
			rd_ptr    <= '0;
			rd_active <= 1'b0;
			px_tick   <= 1'b0;
			spx_en    <= 1'b0;
			lbuf      <= '{default: '0};
		end
		else
		begin
			if (wr_en)
				lbuf[l_sel][wr_addr] <= wr_data;  // later sprite overwrites
			if (rd_active && phase == 2'd1)
				lbuf[~l_sel][rd_ptr] <= '0;       // clear after read

			// ------------------------------------------------------------------
			// readout, one pixel per PIXEL_CLOCKS
			// ------------------------------------------------------------------
			px_tick <= rd_now;
			if (rd_now)
			begin
				spixel <= rd_data[COLOR_W-1:0];
				spx_en <= rd_data[COLOR_W];
			end

			if (line_start)
			begin
				l_sel     <= ~l_sel;
				phase     <= 2'd1;
				rd_ptr    <= '0;
				rd_active <= 1'b1;
			end
			else if (rd_active)
			begin
				phase <= phase + 1'b1;
				if (phase == 2'(PIXEL_CLOCKS - 1))
				begin
					rd_ptr <= rd_ptr + 1'b1;
					if (rd_ptr == LINE_ADDR_W'(LINE_PIXELS - 1))
						rd_active <= 1'b0;  // rest of line stays dark
				end
			end
		end
	end

endmodule

/* logic/sprite_unit.sv */
`timescale 1ns/1ps

module sprite_unit (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              line_start,
	input  logic                              pre_vline,
	input  logic                              host_we,
	input  logic [sprite_pkg::DESC_ADDR_W:0]  host_addr,
	input  logic [7:0]                        host_wdata,
	output logic [sprite_pkg::MEM_ADDR_W-1:0] spr_addr,
	output logic                              spr_mrq,
	input  logic [sprite_pkg::WORD_W-1:0]     spr_dat,
	input  logic                              spr_drdy,
	output logic [sprite_pkg::COLOR_W-1:0]    spixel,
	output logic                              spx_en,
	output logic                              px_tick,
	output logic                              busy
);
	import sprite_pkg::*;

	logic [DESC_ADDR_W-1:0] desc_addr;
	logic [7:0]             desc_data;
	logic [DESC_ADDR_W-1:0] pal_addr;
	logic [COLOR_W-1:0]     pal_color;
	logic                   wr_en;
	logic [LINE_ADDR_W-1:0] wr_addr;
	logic [COLOR_W:0]       wr_data;

	// ----------------------------------------------------------------------
	// host registers, engine, line buffer
	// ----------------------------------------------------------------------
	sprite_regs u_regs (
		.clk        (clk),
		.reset      (reset),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.desc_addr  (desc_addr),
		.desc_data  (desc_data),
		.pal_addr   (pal_addr),
		.pal_color  (pal_color)
	);

	sprite_engine u_engine (
		.clk        (clk),
		.reset      (reset),
		.line_start (line_start),
		.pre_vline  (pre_vline),
		.desc_addr  (desc_addr),
		.desc_data  (desc_data),
		.pal_addr   (pal_addr),
		.pal_color  (pal_color),
		.spr_addr   (spr_addr),
		.spr_mrq    (spr_mrq),
		.spr_dat    (spr_dat),
		.spr_drdy   (spr_drdy),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.busy       (busy)
	);

	line_buffer u_lbuf (
		.clk        (clk),
		.reset      (reset),
		.line_start (line_start),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.l_sel      (),
		.spixel     (spixel),
		.spx_en     (spx_en),
		.px_tick    (px_tick)
	);

endmodule

/* testbench/sprite_unit_properties.sv */
`timescale 1ns/1ps

module sprite_unit_properties (
	input logic                              clk,
	input logic                              reset,
	input logic                              line_start,
	input logic [sprite_pkg::MEM_ADDR_W-1:0] spr_addr,
	input logic                              spr_mrq,
	input logic                              spr_drdy,
	input logic                              px_tick,
	input logic                              busy
);

	int fail_count = 0;

	// ----------------------------------------------------------------------
	// memory request, scan length, readout pacing
	// ----------------------------------------------------------------------
	a_mrq_hold: assert property (@(posedge clk) disable iff (reset)
		(spr_mrq && !spr_drdy) |=> (spr_mrq && $stable(spr_addr)))
	else
	begin
		fail_count++;
		$error("spr_mrq or spr_addr changed before spr_drdy");
	end

	a_scan_done: assert property (@(posedge clk) disable iff (reset)
		line_start |-> !busy)  // scan fits in one line
	else
	begin
		fail_count++;
		$error("busy still high at line_start");
	end

	a_tick_gap: assert property (@(posedge clk) disable iff (reset)
		px_tick |=> !px_tick)
	else
	begin
		fail_count++;
		$error("px_tick high in two consecutive cycles");
	end

endmodule

bind sprite_unit sprite_unit_properties u_props (
	.clk        (clk),
	.reset      (reset),
	.line_start (line_start),
	.spr_addr   (spr_addr),
	.spr_mrq    (spr_mrq),
	.spr_drdy   (spr_drdy),
	.px_tick    (px_tick),
	.busy       (busy)
);

/* testbench/sprite_unit_tb.sv */
`timescale 1ns/1ps

module sprite_unit_tb;
	import sprite_pkg::*;

	localparam int LINE_CLOCKS = 1600;  // clk between line_start pulses
	localparam int N_TESTS     = 5;
	localparam int N_SPR       = 8;
	localparam int N_DELAYS    = 256;

	logic        clk = 1'b0;
	logic        reset;
	logic        line_start;
	logic        pre_vline;
	logic        host_we;
	logic [8:0]  host_addr;
	logic [7:0]  host_wdata;
	logic [20:0] spr_addr;
	logic        spr_mrq;
	logic [15:0] spr_dat;
	logic        spr_drdy;
	logic [5:0]  spixel;
	logic        spx_en;
	logic        px_tick;
	logic        busy;

	// test table, one row per test
	string test_name [N_TESTS] = '{"empty", "true_colour", "palette", "tall", "overlap"};
	int    test_lines [N_TESTS] = '{3, 4, 4, 7, 3};

	// sprite rows: test, sprite, mode, pal, x, xsz, y, ysz, adr
	int spr_tab [N_SPR][9] = '{
		'{1,  2, 3, 'h00,  10, 5, 0, 3, 'h000100},
		'{2,  0, 1, 'h13, 100, 3, 1, 2, 'h01a0f0},
		'{2,  5, 2, 'h2d, 200, 4, 0, 3, 'h00a000},
		'{3,  7, 2, 'h08, 350, 3, 2, 4, 'h1ffff8},
		'{4,  3, 3, 'h00,  60, 4, 0, 1, 'h000300},
		'{4,  9, 1, 'h21,  63, 2, 0, 1, 'h004444},
		'{4, 12, 0, 'h3f,  60, 4, 0, 8, 'h000500},
		'{4, 31, 2, 'h17,  62, 1, 0, 1, 'h012345}
	};

	logic [7:0]  desc_img [256];       // mirror of host descriptor writes
	int          ref_offs [NUM_SPRITES];
	int          ref_vline;
	logic [6:0]  drawn_exp [512];      // {opaque, colour} drawn this line
	logic [6:0]  shown_exp [LINE_PIXELS];
	int          px_idx;
	int unsigned mem_delay [N_DELAYS];
	int          mem_req_n;
	int          mem_wait;
	logic        mem_pending;
	int unsigned seed;
	int          n_checks;
	int          n_errors;
	int          cycle_count;
	int          cycle_limit;
	string       cur_name;

	sprite_unit u_sprite_unit (
		.clk        (clk),
		.reset      (reset),
		.line_start (line_start),
		.pre_vline  (pre_vline),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.spr_addr   (spr_addr),
		.spr_mrq    (spr_mrq),
		.spr_dat    (spr_dat),
		.spr_drdy   (spr_drdy),
		.spixel     (spixel),
		.spx_en     (spx_en),
		.px_tick    (px_tick),
		.busy       (busy)
	);

	always #5 clk = ~clk;

	// ----------------------------------------------------------------------
	// memory contents and palette values
	// ----------------------------------------------------------------------
	function automatic logic [15:0] mem_word(input int a);
		logic [20:0] ad;
		logic [20:0] rot;
		ad  = a;
		rot = {ad[12:0], ad[20:13]};  // rotate left by 8
		return ad[15:0] ^ rot[20:5] ^ 16'h9c35;
	endfunction

	function automatic logic [5:0] pal_value(input int i);
		int v;
		v = (i * 37 + 11) ^ (i >> 3);
		return v[5:0];
	endfunction

	function automatic logic [6:0] pixel_value(input logic [15:0] word, input int mode,
		input logic [5:0] pal, input int p);
		logic [3:0] idx;
		logic [7:0] tc;
		if (mode == CRES_4C)
		begin
			idx = (word >> (14 - 2 * p)) & 16'h3;
			return (idx == 0) ? 7'h00 : {1'b1, pal_value({pal, idx[1:0]})};
		end
		else if (mode == CRES_16C)
		begin
			idx = (word >> (12 - 4 * p)) & 16'hf;
			return (idx == 0) ? 7'h00 : {1'b1, pal_value({pal[5:2], idx})};
		end
		tc = (p == 0) ? word[15:8] : word[7:0];  // high byte first
		return tc[7] ? {1'b1, tc[5:0]} : 7'h00;
	endfunction

	// expected line buffer contents for one drawn line
	task automatic render_line(input int vl);
		int s, base, mode, ypos, ysz, x, xsz, adr, off, w, p, npix;
		logic [5:0]  pal;
		logic [6:0]  pix;
		for (x = 0; x < 512; x++)
			drawn_exp[x] = 7'h00;
		for (s = 0; s < NUM_SPRITES; s++)
		begin
			base = s * 8;
			mode = desc_img[base + REG_MODE_PAL][7:6];
			pal  = desc_img[base + REG_MODE_PAL][5:0];
			ypos = {desc_img[base + REG_YPOS_HI_YSZ][0], desc_img[base + REG_YPOS_LO]};
			ysz  = desc_img[base + REG_YPOS_HI_YSZ][7:1];
			if (mode != CRES_OFF && vl >= ypos && vl < ypos + ysz)
			begin
				x    = {desc_img[base + REG_XPOS_HI_XSZ][0], desc_img[base + REG_XPOS_LO]};
				xsz  = desc_img[base + REG_XPOS_HI_XSZ][7:1];
				adr  = {desc_img[base + REG_ADR_HI][4:0], desc_img[base + REG_ADR_MID],
					desc_img[base + REG_ADR_LO]};
				off  = (vl == ypos) ? 0 : ref_offs[s];
				npix = (mode == CRES_4C) ? 8 : (mode == CRES_16C) ? 4 : 2;
				for (w = 0; w < xsz; w++)
				begin
					for (p = 0; p < npix; p++)
					begin
						pix = pixel_value(mem_word((adr + (off + w) % 16384) % 2097152),
							mode, pal, p);
						if (pix[6])
							drawn_exp[x % 512] = pix;  // later sprite wins
						x++;
					end
				end
				ref_offs[s] = (off + xsz) % 16384;
			end
		end
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		n_checks++;
		if (expected !== actual)
		begin
			n_errors++;
			$display("Error %s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
		end
	endtask

	task automatic host_write(input logic [8:0] addr, input logic [7:0] data);
		host_we    = 1'b1;
		host_addr  = addr;
		host_wdata = data;
		if (!addr[8])
			desc_img[addr[7:0]] = data;
		@(posedge clk);
		#1;
		host_we = 1'b0;
	endtask

	task automatic load_test(input int t);
		int          s;
		int          r;
		logic [4:0]  num;
		logic [8:0]  x;
		logic [8:0]  y;
		logic [6:0]  xsz;
		logic [6:0]  ysz;
		logic [20:0] adr;
		for (s = 0; s < NUM_SPRITES; s++)
			host_write({1'b0, SPRITE_NUM_W'(s), REG_MODE_PAL}, 8'h00);
		for (r = 0; r < N_SPR; r++)
		begin
			if (spr_tab[r][0] == t)
			begin
				num = spr_tab[r][1];
				x   = spr_tab[r][4];
				xsz = spr_tab[r][5];
				y   = spr_tab[r][6];
				ysz = spr_tab[r][7];
				adr = spr_tab[r][8];
				host_write({1'b0, num, REG_XPOS_LO}, x[7:0]);
				host_write({1'b0, num, REG_XPOS_HI_XSZ}, {xsz, x[8]});
				host_write({1'b0, num, REG_YPOS_LO}, y[7:0]);
				host_write({1'b0, num, REG_YPOS_HI_YSZ}, {ysz, y[8]});
				host_write({1'b0, num, REG_ADR_LO}, adr[7:0]);
				host_write({1'b0, num, REG_ADR_MID}, adr[15:8]);
				host_write({1'b0, num, REG_ADR_HI}, {3'b000, adr[20:16]});
				host_write({1'b0, num, REG_MODE_PAL},
					{2'(spr_tab[r][2]), 6'(spr_tab[r][3])});
			end
		end
	endtask

	// one full line period, shows the line drawn in the previous one
	task automatic run_line(input logic first);
		int k;
		check_value("busy before line_start", 0, busy);
		line_start = 1'b1;
		pre_vline  = first;
		ref_vline  = first ? 0 : (ref_vline + 1) % 512;
		for (k = 0; k < LINE_PIXELS; k++)
			shown_exp[k] = drawn_exp[k];
		render_line(ref_vline);
		px_idx = 0;
		@(posedge clk);
		#1;
		line_start = 1'b0;
		pre_vline  = 1'b0;
		repeat (LINE_CLOCKS - 1) @(posedge clk);
		#1;
		check_value("ticks per line", LINE_PIXELS, px_idx);
	endtask

	// ----------------------------------------------------------------------
	// memory model, reply after 0 to 3 clk
	// ----------------------------------------------------------------------
	always @(posedge clk)
	begin
		#1;
		if (spr_drdy)
			spr_drdy = 1'b0;  // taken at this edge
		else if (spr_mrq)
		begin
			if (!mem_pending)
			begin
				mem_pending = 1'b1;
				mem_wait    = mem_delay[mem_req_n % N_DELAYS];
				mem_req_n++;
			end
			if (mem_wait == 0)
			begin
				spr_dat     = mem_word(spr_addr);
				spr_drdy    = 1'b1;
				mem_pending = 1'b0;
			end
			else
				mem_wait--;
		end
	end

	// pixel outputs sampled mid-cycle
	always @(negedge clk)
	begin
		if (!reset && px_tick)
		begin
			if (px_idx < LINE_PIXELS)
				check_value($sformatf("pixel %0d", px_idx), shown_exp[px_idx],
					spx_en ? {1'b1, spixel} : 7'h00);
			px_idx++;
		end
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= cycle_limit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("Test failed");
			$finish;
		end
	end

	initial
	begin
		reset       = 1'b1;
		line_start  = 1'b0;
		pre_vline   = 1'b0;
		host_we     = 1'b0;
		host_addr   = '0;
		host_wdata  = '0;
		spr_dat     = '0;
		spr_drdy    = 1'b0;
		mem_pending = 1'b0;
		mem_req_n   = 0;
		mem_wait    = 0;
		n_checks    = 0;
		n_errors    = 0;
		cycle_count = 0;
		ref_vline   = 0;
		px_idx      = 0;
		cur_name    = "reset";
		seed        = 32'h2100_6214;
		mem_delay[0] = $urandom(seed) % 4;
		for (int i = 1; i < N_DELAYS; i++)
			mem_delay[i] = $urandom % 4;
		cycle_limit = 2000;
		for (int t = 0; t < N_TESTS; t++)
			cycle_limit += test_lines[t] * LINE_CLOCKS;
		for (int i = 0; i < 256; i++)
			desc_img[i] = 8'h00;
		for (int i = 0; i < 512; i++)
			drawn_exp[i] = 7'h00;
		for (int i = 0; i < NUM_SPRITES; i++)
			ref_offs[i] = 0;

		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int i = 0; i < 256; i++)
			host_write({1'b1, 8'(i)}, {2'b00, pal_value(i)});
		check_value("idle outputs", 0, {spx_en, busy, spr_mrq, px_tick});

		for (int t = 0; t < N_TESTS; t++)
		begin
			cur_name = test_name[t];
			load_test(t);
			for (int l = 0; l < test_lines[t]; l++)
				run_line(l == 0);
		end

		n_errors += u_sprite_unit.u_props.fail_count;
		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* sprite_unit.f */
logic/sprite_pkg.sv
logic/sprite_regs.sv
logic/sprite_engine.sv
logic/line_buffer.sv
logic/sprite_unit.sv
testbench/sprite_unit_properties.sv
testbench/sprite_unit_tb.sv

/* Bender.yml */
package:
  name: sprite_unit

sources:
  - files:
      - logic/sprite_pkg.sv
      - logic/sprite_regs.sv
      - logic/sprite_engine.sv
      - logic/line_buffer.sv
      - logic/sprite_unit.sv
  - target: test
    files:
      - testbench/sprite_unit_properties.sv
      - testbench/sprite_unit_tb.sv
